/* upd7800_alu_consts.svh */
// uPD7800 ALU constants
// Datapath widths, BCD limits and status word bit positions
// shared by the arithmetic and flag section

`ifndef UPD7800_ALU_CONSTS_SVH
`define UPD7800_ALU_CONSTS_SVH

//////////////////////////////////////////////////
// Datapath widths

`define UPD_DATA_W 8
`define UPD_NIB_W 4

//////////////////////////////////////////////////
// Decimal adjust

// Largest legal BCD digit
`define UPD_BCD_MAX 9
// Added to a digit that overflowed
`define UPD_BCD_ADJ 6

//////////////////////////////////////////////////
// Status word bit positions

`define UPD_PSW_Z 6
`define UPD_PSW_SK 5
`define UPD_PSW_HC 4
`define UPD_PSW_CY 0

`endif

/* upd7800_alu_pkg.sv */
// uPD7800 ALU types
// Operation, carry-in and skip source selects, and the
// processor status word with its byte and flag views

`default_nettype none

`include "upd7800_alu_consts.svh"

package upd7800_alu_pkg;

  // ALU operation, one per execute step
  typedef enum logic [3:0] {
    OP_NONE = 4'd0,
    OP_SUM  = 4'd1,
    OP_INC  = 4'd2,
    OP_DEC  = 4'd3,
    OP_OR   = 4'd4,
    OP_AND  = 4'd5,
    OP_EOR  = 4'd6,
    OP_LSL  = 4'd7,
    OP_ROL  = 4'd8,
    OP_LSR  = 4'd9,
    OP_ROR  = 4'd10
  } alu_op_e;

  // Carry into the adder and rotates
  typedef enum logic [1:0] {
    CIN_NONE   = 2'd0,
    CIN_CCO    = 2'd1,  // carry out of the previous operation
    CIN_ONE    = 2'd2,
    CIN_PSW_CY = 2'd3
  } carry_sel_e;

  // Skip flag source, PSW_SK keeps the flag as it is
  typedef enum logic [2:0] {
    SKS_PSW_SK = 3'd0,
    SKS_ONE    = 3'd1,
    SKS_C      = 3'd2,
    SKS_NC     = 3'd3,
    SKS_Z      = 3'd4,
    SKS_NZ     = 3'd5,
    SKS_ZERO   = 3'd6
  } skip_sel_e;

  // Flag layout, bit 7 first
  typedef struct packed {
    logic rsv7;
    logic z;    // zero
    logic sk;   // skip next instruction
    logic hc;   // half carry
    logic l1;   // byte string effect
    logic l0;   // word string effect
    logic rsv1;
    logic cy;   // carry
  } psw_flags_t;

  typedef union packed {
    logic [`UPD_DATA_W-1:0] raw;
    psw_flags_t             flags;
  } psw_u;

endpackage

`default_nettype wire

/* alu_operands.sv */
// uPD7800 ALU operand stage
// A and B operand latches, decimal adjust constants,
// B conditioning for INC/DEC/invert and carry-in selection

`timescale 1ns/10ps
`default_nettype none

`include "upd7800_alu_consts.svh"

module alu_operands (
  input  wire logic                        CLK,
  input  wire logic                        arst_n,
  input  wire logic [`UPD_DATA_W-1:0]      data_in,
  input  wire logic                        load_a,
  input  wire logic                        load_b,
  input  wire logic                        zero_b,
  input  wire upd7800_alu_pkg::alu_op_e    op,
  input  wire upd7800_alu_pkg::carry_sel_e carry_sel,
  input  wire logic                        invert_b,
  input  wire logic                        daa,
  input  wire logic                        carry,
  input  wire upd7800_alu_pkg::psw_u       psw,
  output logic [`UPD_DATA_W-1:0]           a_val,
  output logic [`UPD_DATA_W-1:0]           b_eff,
  output logic                             carry_in,
  output logic                             dec_carry
);

  localparam logic [`UPD_NIB_W-1:0] ADJ_NIB = `UPD_BCD_ADJ;

  logic [`UPD_DATA_W-1:0] a_q;
  logic [`UPD_DATA_W-1:0] b_q;
  logic [`UPD_NIB_W-1:0]  a_lo;
  logic [`UPD_NIB_W-1:0]  a_hi;
  logic                   psw_cy;
  logic                   psw_hc;
  logic                   adj_hi;
  logic                   adj_lo;
  logic                   inc_dec;

  //////////////////////////////////////////////////
  // Operand latches

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      a_q <= '0;
      b_q <= '0;
    end else begin
      if (load_a)
        a_q <= data_in;
      // Clear wins over a load
      if (zero_b)
        b_q <= '0;
      else if (load_b)
        b_q <= data_in;
    end
  end

  assign a_val = a_q;

  //////////////////////////////////////////////////
  // Decimal adjust

  assign a_lo   = a_q[`UPD_NIB_W-1:0];
  assign a_hi   = a_q[`UPD_DATA_W-1:`UPD_NIB_W];
  assign psw_cy = psw.raw[`UPD_PSW_CY];
  assign psw_hc = psw.raw[`UPD_PSW_HC];

  // Low digit overflow can still push a 9 in the high digit over
  assign adj_hi = psw_cy | (a_hi > `UPD_BCD_MAX) |
                  (~psw_hc & (a_lo > `UPD_BCD_MAX) & (a_hi == `UPD_BCD_MAX));
  assign adj_lo = psw_hc | (a_lo > `UPD_BCD_MAX);

  assign dec_carry = psw_cy | adj_hi;

  //////////////////////////////////////////////////
  // B conditioning and carry in

  assign inc_dec = (op == upd7800_alu_pkg::OP_INC) | (op == upd7800_alu_pkg::OP_DEC);

  always_comb begin
    b_eff = b_q;
    if (inc_dec)
      b_eff = '0;
    if (daa) begin
      b_eff[`UPD_DATA_W-1:`UPD_NIB_W] = adj_hi ? ADJ_NIB : '0;
      b_eff[`UPD_NIB_W-1:0]           = adj_lo ? ADJ_NIB : '0;
    end
    // DEC adds the ones complement of zero plus no carry
    if (invert_b || (op == upd7800_alu_pkg::OP_DEC))
      b_eff = ~b_eff;
  end

  always_comb begin
    case (carry_sel)
      upd7800_alu_pkg::CIN_CCO:    carry_in = carry;
      upd7800_alu_pkg::CIN_ONE:    carry_in = 1'b1;
      upd7800_alu_pkg::CIN_PSW_CY: carry_in = psw_cy;
      default:                     carry_in = 1'b0;
    endcase
    if (op == upd7800_alu_pkg::OP_INC)
      carry_in = 1'b1;
  end

  // Adjust constants only make sense on the adder
  a_daa_sum: assert property (@(posedge CLK) disable iff (!arst_n)
    daa |-> (op == upd7800_alu_pkg::OP_SUM));

endmodule

`default_nettype wire

/* alu_exec.sv */
// uPD7800 ALU execute unit
// Two-nibble adder with decimal carry, logic operations and
// shifts/rotates through carry; result and flags are registered

`timescale 1ns/10ps
`default_nettype none

`include "upd7800_alu_consts.svh"

module alu_exec (
  input  wire logic                     CLK,
  input  wire logic                     arst_n,
  input  wire logic                     step,
  input  wire upd7800_alu_pkg::alu_op_e op,
  input  wire logic                     daa,
  input  wire logic [`UPD_DATA_W-1:0]   a_val,
  input  wire logic [`UPD_DATA_W-1:0]   b_eff,
  input  wire logic                     carry_in,
  input  wire logic                     dec_carry,
  output logic [`UPD_DATA_W-1:0]        result,
  output logic                          carry,
  output logic                          half_carry
);

  logic [`UPD_NIB_W:0] lo_sum;
  logic [`UPD_NIB_W:0] hi_sum;
  logic                shift_in;

  //////////////////////////////////////////////////
  // Nibble adder

  // Low nibble with carry in, high nibble takes its carry
  assign lo_sum = {1'b0, a_val[`UPD_NIB_W-1:0]} + {1'b0, b_eff[`UPD_NIB_W-1:0]} +
                  {{`UPD_NIB_W{1'b0}}, carry_in};
  assign hi_sum = {1'b0, a_val[`UPD_DATA_W-1:`UPD_NIB_W]} +
                  {1'b0, b_eff[`UPD_DATA_W-1:`UPD_NIB_W]} +
                  {{`UPD_NIB_W{1'b0}}, lo_sum[`UPD_NIB_W]};

  // Rotates feed the carry in, plain shifts feed zero
  assign shift_in = carry_in &
                    ((op == upd7800_alu_pkg::OP_ROL) | (op == upd7800_alu_pkg::OP_ROR));

  //////////////////////////////////////////////////
  // Result and flag registers

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      result     <= '0;
      carry      <= 1'b0;
      half_carry <= 1'b0;
    end else if (step) begin
      case (op)
        upd7800_alu_pkg::OP_SUM,
        upd7800_alu_pkg::OP_INC,
        upd7800_alu_pkg::OP_DEC: begin
          result     <= {hi_sum[`UPD_NIB_W-1:0], lo_sum[`UPD_NIB_W-1:0]};
          carry      <= daa ? dec_carry : hi_sum[`UPD_NIB_W];
          half_carry <= (lo_sum > `UPD_BCD_MAX);
        end
        upd7800_alu_pkg::OP_OR:
          result <= a_val | b_eff;
        upd7800_alu_pkg::OP_AND:
          result <= a_val & b_eff;
        upd7800_alu_pkg::OP_EOR:
          result <= a_val ^ b_eff;
        upd7800_alu_pkg::OP_LSL,
        upd7800_alu_pkg::OP_ROL:
          {carry, result} <= {a_val, shift_in};
        upd7800_alu_pkg::OP_LSR,
        upd7800_alu_pkg::OP_ROR:
          {result, carry} <= {shift_in, a_val};
        // NONE holds everything
        default: ;
      endcase
    end
  end

  // Operand latches are reset, so any X here comes from the control inputs
  a_result_known: assert property (@(posedge CLK) disable iff (!arst_n)
    (step && (op != upd7800_alu_pkg::OP_NONE)) |=> !$isunknown(result));

endmodule

`default_nettype wire

/* psw_reg.sv */
// uPD7800 processor status word
// Byte load, zero/carry/half-carry updates and the skip flag
// source select, all applied on the execute step

`timescale 1ns/10ps
`default_nettype none

`include "upd7800_alu_consts.svh"

module psw_reg (
  input  wire logic                       CLK,
  input  wire logic                       arst_n,
  input  wire logic                       step,
  input  wire logic                       psw_load,
  input  wire logic [`UPD_DATA_W-1:0]     psw_in,
  input  wire logic                       set_z,
  input  wire logic                       set_cy,
  input  wire logic                       set_hc,
  input  wire upd7800_alu_pkg::skip_sel_e skip_sel,
  input  wire logic [`UPD_DATA_W-1:0]     result,
  input  wire logic                       carry,
  input  wire logic                       half_carry,
  output upd7800_alu_pkg::psw_u           psw
);

  logic result_zero;
  logic sk_src;

  assign result_zero = ~|result;

  //////////////////////////////////////////////////
  // Skip flag source

  always_comb begin
    case (skip_sel)
      upd7800_alu_pkg::SKS_ONE:  sk_src = 1'b1;
      upd7800_alu_pkg::SKS_C:    sk_src = carry;
      upd7800_alu_pkg::SKS_NC:   sk_src = ~carry;
      upd7800_alu_pkg::SKS_Z:    sk_src = result_zero;
      upd7800_alu_pkg::SKS_NZ:   sk_src = ~result_zero;
      upd7800_alu_pkg::SKS_ZERO: sk_src = 1'b0;
      // Hold
      default:                   sk_src = psw.raw[`UPD_PSW_SK];
    endcase
  end

  //////////////////////////////////////////////////
  // Status word register

  // Flag writes follow the load, so they override loaded bits
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      psw.raw <= '0;
    end else if (step) begin
      if (psw_load)
        psw.raw <= psw_in;
      if (set_z)
        psw.flags.z <= result_zero;
      if (set_cy)
        psw.flags.cy <= carry;
      if (set_hc)
        psw.flags.hc <= half_carry;
      if (skip_sel != upd7800_alu_pkg::SKS_PSW_SK)
        psw.flags.sk <= sk_src;
    end
  end

  //////////////////////////////////////////////////
  // Checks

  // First edge out of reset sees a clean word
  a_reset_clear: assert property (@(posedge CLK)
    $rose(arst_n) |-> (psw.raw == '0));

endmodule

`default_nettype wire

/* upd7800_alu.sv */
// uPD7800 arithmetic and flag section
// Operand latches, execute unit and status word, driven by
// plain strobes that stand in for the microcode controls

`timescale 1ns/10ps
`default_nettype none

`include "upd7800_alu_consts.svh"

module upd7800_alu (
  input  wire logic                        CLK,
  input  wire logic                        arst_n,
  input  wire logic [`UPD_DATA_W-1:0]      data_in,
  input  wire logic                        load_a,
  input  wire logic                        load_b,
  input  wire logic                        zero_b,
  input  wire logic                        step,
  input  wire logic                        invert_b,
  input  wire logic                        daa,
  input  wire logic                        psw_load,
  input  wire logic                        set_z,
  input  wire logic                        set_cy,
  input  wire logic                        set_hc,
  input  wire upd7800_alu_pkg::alu_op_e    op,
  input  wire upd7800_alu_pkg::carry_sel_e carry_sel,
  input  wire upd7800_alu_pkg::skip_sel_e  skip_sel,
  input  wire logic [`UPD_DATA_W-1:0]      psw_in,
  output logic [`UPD_DATA_W-1:0]           result,
  output logic                             carry,
  output logic                             half_carry,
  output logic [`UPD_DATA_W-1:0]           psw
);

  logic [`UPD_DATA_W-1:0] a_val;
  logic [`UPD_DATA_W-1:0] b_eff;
  logic                   carry_in;
  logic                   dec_carry;
  upd7800_alu_pkg::psw_u  psw_w;

  //////////////////////////////////////////////////
  // Operands

  alu_operands u_operands (
    .CLK       (CLK),
    .arst_n    (arst_n),
    .data_in   (data_in),
    .load_a    (load_a),
    .load_b    (load_b),
    .zero_b    (zero_b),
    .op        (op),
    .carry_sel (carry_sel),
    .invert_b  (invert_b),
    .daa       (daa),
    .carry     (carry),
    .psw       (psw_w),
    .a_val     (a_val),
    .b_eff     (b_eff),
    .carry_in  (carry_in),
    .dec_carry (dec_carry)
  );

  //////////////////////////////////////////////////
  // Execute

  alu_exec u_exec (
    .CLK        (CLK),
    .arst_n     (arst_n),
    .step       (step),
    .op         (op),
    .daa        (daa),
    .a_val      (a_val),
    .b_eff      (b_eff),
    .carry_in   (carry_in),
    .dec_carry  (dec_carry),
    .result     (result),
    .carry      (carry),
    .half_carry (half_carry)
  );

  //////////////////////////////////////////////////
  // Status word

  psw_reg u_psw (
    .CLK        (CLK),
    .arst_n     (arst_n),
    .step       (step),
    .psw_load   (psw_load),
    .psw_in     (psw_in),
    .set_z      (set_z),
    .set_cy     (set_cy),
    .set_hc     (set_hc),
    .skip_sel   (skip_sel),
    .result     (result),
    .carry      (carry),
    .half_carry (half_carry),
    .psw        (psw_w)
  );

  // Byte view out
  assign psw = psw_w.raw;

endmodule

`default_nettype wire

/* tb_upd7800_alu.sv */
// uPD7800 ALU testbench
// Random stimulus from an LFSR, checked every cycle against a
// cycle model of the operand latches, execute unit and status word

`timescale 1ns/10ps
`default_nettype none

`include "upd7800_alu_consts.svh"

module tb_upd7800_alu;

  localparam logic [31:0] SEED = 32'h38a95512;
  localparam int RESET_CYC     = 5;
  localparam int N_ARITH       = 400;
  localparam int N_LOGIC       = 300;
  localparam int N_DEC         = 60;
  localparam int N_PSW         = 100;
  localparam int N_SKIP_ROUNDS = 20;
  // Decimal pair is 5 cycles, status word write 2, skip round 7 x 3, one final idle
  localparam int TEST_CYC    = N_ARITH + N_LOGIC + 5 * N_DEC + 2 * N_PSW +
                               21 * N_SKIP_ROUNDS + 1;
  localparam int CYCLE_LIMIT = 2 * TEST_CYC + RESET_CYC;

  logic                        CLK;
  logic                        arst_n;
  logic [7:0]                  data_in;
  logic                        load_a;
  logic                        load_b;
  logic                        zero_b;
  logic                        step;
  logic                        invert_b;
  logic                        daa;
  logic                        psw_load;
  logic                        set_z;
  logic                        set_cy;
  logic                        set_hc;
  upd7800_alu_pkg::alu_op_e    op;
  upd7800_alu_pkg::carry_sel_e carry_sel;
  upd7800_alu_pkg::skip_sel_e  skip_sel;
  logic [7:0]                  psw_in;
  logic [7:0]                  result;
  logic                        carry;
  logic                        half_carry;
  logic [7:0]                  psw;

  // Model state
  logic [7:0]  m_a;
  logic [7:0]  m_b;
  logic [7:0]  m_result;
  logic        m_carry;
  logic        m_hc;
  logic [7:0]  m_psw;
  logic [31:0] lfsr_state;
  int          cycle_cnt = 0;

  upd7800_alu uut (
    .CLK        (CLK),
    .arst_n     (arst_n),
    .data_in    (data_in),
    .load_a     (load_a),
    .load_b     (load_b),
    .zero_b     (zero_b),
    .step       (step),
    .invert_b   (invert_b),
    .daa        (daa),
    .psw_load   (psw_load),
    .set_z      (set_z),
    .set_cy     (set_cy),
    .set_hc     (set_hc),
    .op         (op),
    .carry_sel  (carry_sel),
    .skip_sel   (skip_sel),
    .psw_in     (psw_in),
    .result     (result),
    .carry      (carry),
    .half_carry (half_carry),
    .psw        (psw)
  );

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  always @(posedge CLK) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("TEST FAIL");
      $fatal(1, "Timeout: tests did not finish within %0d cycles", CYCLE_LIMIT);
    end
  end

  //////////////////////////////////////////////////
  // Random numbers

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    lfsr_step = {s[30:0], fb};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    rand_bits = v;
  endfunction

  function automatic logic rand_bit();
    logic [31:0] v;
    v = rand_bits(1);
    rand_bit = v[0];
  endfunction

  function automatic logic [7:0] rand_byte();
    logic [31:0] v;
    v = rand_bits(8);
    rand_byte = v[7:0];
  endfunction

  function automatic upd7800_alu_pkg::skip_sel_e rand_skip();
    logic [31:0] v;
    v = rand_bits(3) % 7;
    rand_skip = upd7800_alu_pkg::skip_sel_e'(v[2:0]);
  endfunction

  function automatic logic [3:0] bcd_digit();
    logic [31:0] v;
    v = rand_bits(4) % 10;
    bcd_digit = v[3:0];
  endfunction

  //////////////////////////////////////////////////
  // Checking and cycle model

  task automatic check(input string name, input logic [7:0] expected, input logic [7:0] actual);
    if (actual !== expected) begin
      $display("ERR %s: expected %h, actual %h", name, expected, actual);
      $display("TEST FAIL");
      $fatal(1, "Value mismatch in %s", name);
    end
  endtask

  task automatic idle_inputs();
    data_in   = 8'h00;
    load_a    = 1'b0;
    load_b    = 1'b0;
    zero_b    = 1'b0;
    step      = 1'b0;
    invert_b  = 1'b0;
    daa       = 1'b0;
    psw_load  = 1'b0;
    set_z     = 1'b0;
    set_cy    = 1'b0;
    set_hc    = 1'b0;
    op        = upd7800_alu_pkg::OP_NONE;
    carry_sel = upd7800_alu_pkg::CIN_NONE;
    skip_sel  = upd7800_alu_pkg::SKS_PSW_SK;
    psw_in    = 8'h00;
  endtask

  // Predicts the next state from the inputs, clocks once and compares
  task automatic run_cycle(input string name);
    logic [7:0] b_c;
    logic [7:0] n_a;
    logic [7:0] n_b;
    logic [7:0] n_res;
    logic [7:0] n_psw;
    logic       n_cy;
    logic       n_hc;
    logic       cin;
    logic       adj_hi;
    logic       adj_lo;
    logic       r_zero;
    int         lo;
    int         hi;
    adj_hi = 1'b0;
    adj_lo = 1'b0;
    b_c = m_b;
    if (op == upd7800_alu_pkg::OP_INC || op == upd7800_alu_pkg::OP_DEC)
      b_c = 8'h00;
    if (daa) begin
      adj_lo = m_psw[`UPD_PSW_HC] || (m_a[3:0] > 4'd9);
      adj_hi = m_psw[`UPD_PSW_CY] || (m_a[7:4] > 4'd9) ||
               (!m_psw[`UPD_PSW_HC] && (m_a[3:0] > 4'd9) && (m_a[7:4] == 4'd9));
      b_c = {(adj_hi ? 4'd6 : 4'd0), (adj_lo ? 4'd6 : 4'd0)};
    end
    if (invert_b || op == upd7800_alu_pkg::OP_DEC)
      b_c = ~b_c;
    case (carry_sel)
      upd7800_alu_pkg::CIN_CCO:    cin = m_carry;
      upd7800_alu_pkg::CIN_ONE:    cin = 1'b1;
      upd7800_alu_pkg::CIN_PSW_CY: cin = m_psw[`UPD_PSW_CY];
      default:                     cin = 1'b0;
    endcase
    if (op == upd7800_alu_pkg::OP_INC)
      cin = 1'b1;
    n_res = m_result;
    n_cy  = m_carry;
    n_hc  = m_hc;
    if (step) begin
      case (op)
        upd7800_alu_pkg::OP_SUM, upd7800_alu_pkg::OP_INC, upd7800_alu_pkg::OP_DEC: begin
          lo = int'(m_a[3:0]) + int'(b_c[3:0]) + int'(cin);
          hi = int'(m_a[7:4]) + int'(b_c[7:4]) + ((lo > 15) ? 1 : 0);
          n_res = {hi[3:0], lo[3:0]};
          n_hc  = (lo > 9);
          n_cy  = daa ? (m_psw[`UPD_PSW_CY] || adj_hi) : (hi > 15);
        end
        upd7800_alu_pkg::OP_OR:  n_res = m_a | b_c;
        upd7800_alu_pkg::OP_AND: n_res = m_a & b_c;
        upd7800_alu_pkg::OP_EOR: n_res = m_a ^ b_c;
        upd7800_alu_pkg::OP_LSL: begin
          n_cy  = m_a[7];
          n_res = {m_a[6:0], 1'b0};
        end
        upd7800_alu_pkg::OP_ROL: begin
          n_cy  = m_a[7];
          n_res = {m_a[6:0], cin};
        end
        upd7800_alu_pkg::OP_LSR: begin
          n_cy  = m_a[0];
          n_res = {1'b0, m_a[7:1]};
        end
        upd7800_alu_pkg::OP_ROR: begin
          n_cy  = m_a[0];
          n_res = {cin, m_a[7:1]};
        end
        default: ;
      endcase
    end
    // Flags read the result standing before this edge
    r_zero = (m_result == 8'h00);
    n_psw  = m_psw;
    if (step) begin
      if (psw_load)
        n_psw = psw_in;
      if (set_z)
        n_psw[`UPD_PSW_Z] = r_zero;
      if (set_cy)
        n_psw[`UPD_PSW_CY] = m_carry;
      if (set_hc)
        n_psw[`UPD_PSW_HC] = m_hc;
      case (skip_sel)
        upd7800_alu_pkg::SKS_ONE:  n_psw[`UPD_PSW_SK] = 1'b1;
        upd7800_alu_pkg::SKS_C:    n_psw[`UPD_PSW_SK] = m_carry;
        upd7800_alu_pkg::SKS_NC:   n_psw[`UPD_PSW_SK] = !m_carry;
        upd7800_alu_pkg::SKS_Z:    n_psw[`UPD_PSW_SK] = r_zero;
        upd7800_alu_pkg::SKS_NZ:   n_psw[`UPD_PSW_SK] = !r_zero;
        upd7800_alu_pkg::SKS_ZERO: n_psw[`UPD_PSW_SK] = 1'b0;
        default: ;
      endcase
    end
    n_a = load_a ? data_in : m_a;
    n_b = zero_b ? 8'h00 : (load_b ? data_in : m_b);
    @(posedge CLK);
    #1;
    m_a      = n_a;
    m_b      = n_b;
    m_result = n_res;
    m_carry  = n_cy;
    m_hc     = n_hc;
    m_psw    = n_psw;
    check({name, " result"}, m_result, result);
    check({name, " carry"}, {7'b0, m_carry}, {7'b0, carry});
    check({name, " half_carry"}, {7'b0, m_hc}, {7'b0, half_carry});
    check({name, " psw"}, m_psw, psw);
  endtask

  //////////////////////////////////////////////////
  // Test sequences

  // One random cycle with an op from op_first on
  task automatic random_op_cycle(input string name, input int op_first, input int op_count);
    logic [31:0] v;
    int          k;
    logic [3:0]  op_v;
    idle_inputs();
    k = op_first + int'(rand_bits(4) % op_count);
    op_v = k[3:0];
    op = upd7800_alu_pkg::alu_op_e'(op_v);
    v = rand_bits(2);
    carry_sel = upd7800_alu_pkg::carry_sel_e'(v[1:0]);
    step     = (rand_bits(3) != 0);
    invert_b = rand_bit();
    data_in  = rand_byte();
    load_a   = rand_bit();
    load_b   = rand_bit();
    zero_b   = (rand_bits(3) == 0);
    psw_load = (rand_bits(3) == 0);
    psw_in   = rand_byte();
    set_z    = rand_bit();
    set_cy   = rand_bit();
    set_hc   = rand_bit();
    skip_sel = rand_skip();
    run_cycle(name);
  endtask

  task automatic decimal_pair();
    logic [7:0] x;
    logic [7:0] y;
    logic [7:0] bcd;
    logic       bcd_c;
    int         dsum;
    int         d_hi;
    int         d_lo;
    int         s_lo;
    x = {bcd_digit(), bcd_digit()};
    y = {bcd_digit(), bcd_digit()};
    idle_inputs();
    load_a  = 1'b1;
    data_in = x;
    run_cycle("decimal load a");
    idle_inputs();
    load_b  = 1'b1;
    data_in = y;
    run_cycle("decimal load b");
    idle_inputs();
    step = 1'b1;
    op   = upd7800_alu_pkg::OP_SUM;
    run_cycle("decimal add");
    // Binary sum back into A, flags from the add
    idle_inputs();
    step    = 1'b1;
    set_cy  = 1'b1;
    set_hc  = 1'b1;
    load_a  = 1'b1;
    data_in = m_result;
    zero_b  = 1'b1;
    run_cycle("decimal flags");
    idle_inputs();
    step = 1'b1;
    op   = upd7800_alu_pkg::OP_SUM;
    daa  = 1'b1;
    run_cycle("decimal adjust");
    dsum  = int'(x[7:4]) * 10 + int'(x[3:0]) + int'(y[7:4]) * 10 + int'(y[3:0]);
    bcd_c = (dsum >= 100);
    dsum  = dsum % 100;
    d_hi  = dsum / 10;
    d_lo  = dsum % 10;
    bcd   = {d_hi[3:0], d_lo[3:0]};
    s_lo  = int'(x[3:0]) + int'(y[3:0]);
    // The high adjust misses a digit sum of 9 when the low sum is 10 to 15
    // The cycle model still covers that case
    if (!((s_lo >= 10) && (s_lo <= 15) && (int'(x[7:4]) + int'(y[7:4]) == 9))) begin
      check("decimal bcd sum", bcd, result);
      check("decimal carry", {7'b0, bcd_c}, {7'b0, carry});
    end
  endtask

  task automatic psw_write_cycle();
    random_op_cycle("psw setup", 1, 10);
    idle_inputs();
    step     = 1'b1;
    psw_load = 1'b1;
    psw_in   = rand_byte();
    set_z    = rand_bit();
    set_cy   = rand_bit();
    set_hc   = rand_bit();
    skip_sel = rand_skip();
    run_cycle("psw load");
  endtask

  task automatic skip_round(input int sel);
    logic [2:0] sv;
    logic       sk_before;
    sv = sel[2:0];
    random_op_cycle("skip setup", 1, 10);
    // Random SK to start from
    idle_inputs();
    step     = 1'b1;
    psw_load = 1'b1;
    psw_in   = rand_byte();
    run_cycle("skip preload");
    idle_inputs();
    step      = 1'b1;
    skip_sel  = upd7800_alu_pkg::skip_sel_e'(sv);
    sk_before = m_psw[`UPD_PSW_SK];
    run_cycle("skip select");
    if (sv == 3'd0)
      check("skip hold", {7'b0, sk_before}, {7'b0, psw[`UPD_PSW_SK]});
  endtask

  //////////////////////////////////////////////////
  // Main sequence

  initial begin
    lfsr_state = SEED;
    m_a        = 8'h00;
    m_b        = 8'h00;
    m_result   = 8'h00;
    m_carry    = 1'b0;
    m_hc       = 1'b0;
    m_psw      = 8'h00;
    arst_n     = 1'b0;
    idle_inputs();
    repeat (RESET_CYC) @(posedge CLK);
    #1;
    arst_n = 1'b1;
    check("reset psw", 8'h00, psw);
    check("reset result", 8'h00, result);
    check("reset carry", 8'h00, {7'b0, carry});
    check("reset half_carry", 8'h00, {7'b0, half_carry});
    for (int i = 0; i < N_ARITH; i++)
      random_op_cycle("arith", 1, 3);
    for (int i = 0; i < N_LOGIC; i++)
      random_op_cycle("logic shift", 4, 7);
    for (int i = 0; i < N_DEC; i++)
      decimal_pair();
    for (int i = 0; i < N_PSW; i++)
      psw_write_cycle();
    for (int r = 0; r < N_SKIP_ROUNDS; r++) begin
      for (int s = 0; s < 7; s++)
        skip_round(s);
    end
    idle_inputs();
    run_cycle("final idle");
    $display("TEST PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* upd7800_alu.f */
+incdir+.
upd7800_alu_pkg.sv
alu_operands.sv
alu_exec.sv
psw_reg.sv
upd7800_alu.sv
tb_upd7800_alu.sv

/* Bender.yml */
package:
  name: upd7800_alu

sources:
  - include_dirs:
      - .
    files:
      - upd7800_alu_pkg.sv
      - alu_operands.sv
      - alu_exec.sv
      - psw_reg.sv
      - upd7800_alu.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_upd7800_alu.sv
